// ==== rtl/adc_event_pkg.sv ====
package adc_event_pkg;

    ////////////////////////////////////////////////////////////
    // widths and sizes
    ////////////////////////////////////////////////////////////
    localparam int ADC_WIDTH     = 14;  // raw converter bus
    localparam int SAMPLE_WIDTH  = 16;  // after sign extension
    localparam int WORD_WIDTH    = 32;
    localparam int PRE_SAMPLES   = 4;   // pairs ahead of the trigger pair
    localparam int RECORD_WORDS  = 32;
    localparam int NUM_WINDOWS   = 10;  // ring depth in events
    localparam int INDEX_WIDTH   = $clog2(RECORD_WORDS);
    localparam int SLOT_WIDTH    = $clog2(NUM_WINDOWS);
    localparam int COUNT_WIDTH   = 8;   // status bits 7:0
    localparam int DROP_WIDTH    = 16;  // status bits 31:16
    localparam int ADDR_WIDTH    = 12;
    localparam int TRIGGER_LEVEL = -2170;  // at or below fires
    // clocks from the trigger pair leaving capture to the first word at the buffer
    localparam int TIME_LAG      = 1;

    ////////////////////////////////////////////////////////////
    // register map
    ////////////////////////////////////////////////////////////
    localparam logic [ADDR_WIDTH-1:0] ADDR_DATA_BASE = 12'h000;  // 32 words, oldest event
    localparam logic [ADDR_WIDTH-1:0] ADDR_TIME      = 12'h080;
    localparam logic [ADDR_WIDTH-1:0] ADDR_STATUS    = 12'h084;
    localparam logic [ADDR_WIDTH-1:0] ADDR_PPS       = 12'h088;
    localparam logic [ADDR_WIDTH-1:0] ADDR_POP       = 12'h08C;  // write only

    typedef struct packed {
        logic signed [SAMPLE_WIDTH-1:0] a;  // high half
        logic signed [SAMPLE_WIDTH-1:0] b;
    } sample_pair_t;

    // framer fills the pair view, storage only sees bits
    typedef union packed {
        sample_pair_t          pair;
        logic [WORD_WIDTH-1:0] raw;
    } sample_word_u;

    typedef struct packed {
        sample_pair_t pair;
        logic         trigger;
    } capture_t;

    typedef struct packed {
        logic                   valid;
        logic                   first;
        logic                   last;
        logic [INDEX_WIDTH-1:0] index;
        sample_word_u           word;
    } record_word_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] araddr;
        logic                  arvalid;
        logic [ADDR_WIDTH-1:0] awaddr;
        logic                  awvalid;
        logic [WORD_WIDTH-1:0] wdata;
        logic                  wvalid;
        logic                  rready;
        logic                  bready;
    } axil_req_t;

    typedef struct packed {
        logic                  arready;
        logic [WORD_WIDTH-1:0] rdata;
        logic [1:0]            rresp;
        logic                  rvalid;
        logic                  awready;
        logic                  wready;
        logic [1:0]            bresp;
        logic                  bvalid;
    } axil_rsp_t;

endpackage

// ==== rtl/sample_capture.sv ====
`timescale 1ns/100ps

module sample_capture import adc_event_pkg::*;
(
    input  logic                 ADA_DCO,
    input  logic                 hps_fpga_reset_n,
    input  logic [ADC_WIDTH-1:0] ada_d,   // two's complement, valid every clock
    input  logic [ADC_WIDTH-1:0] adb_d,
    output capture_t             capture
);

    logic signed [SAMPLE_WIDTH-1:0] a_ext;
    logic signed [SAMPLE_WIDTH-1:0] b_ext;
    logic                           a_hit;

    // replicate the sign bit up to the sample width
    assign a_ext = {{(SAMPLE_WIDTH-ADC_WIDTH){ada_d[ADC_WIDTH-1]}}, ada_d};
    assign b_ext = {{(SAMPLE_WIDTH-ADC_WIDTH){adb_d[ADC_WIDTH-1]}}, adb_d};

    // negative going pulse on channel A
    assign a_hit = (a_ext <= TRIGGER_LEVEL);

    ////////////////////////////////////////////////////////////
    // one register stage from the pins
    ////////////////////////////////////////////////////////////
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            capture <= '0;
        end
        else
        begin
            capture.pair.a  <= a_ext;
            capture.pair.b  <= b_ext;
            capture.trigger <= a_hit;  // flag travels with its own sample
        end
    end

endmodule

// ==== rtl/time_base.sv ====
`timescale 1ns/100ps

module time_base import adc_event_pkg::*;
(
    input  logic                  ADA_DCO,
    input  logic                  hps_fpga_reset_n,
    input  logic                  pps,          // async to ADA_DCO
    output logic [WORD_WIDTH-1:0] sample_time,  // clocks since reset
    output logic [WORD_WIDTH-1:0] pps_count
);

    logic pps_meta;
    logic pps_sync;
    logic pps_prev;  // last synced level for edge detect
    logic pps_rise;

    assign pps_rise = pps_sync && !pps_prev;

    // free running, wraps after 2^32 samples
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
            sample_time <= '0;
        else
            sample_time <= sample_time + 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // pps synchronizer and rising edge count
    ////////////////////////////////////////////////////////////
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            pps_meta  <= 1'b0;
            pps_sync  <= 1'b0;
            pps_prev  <= 1'b0;
            pps_count <= '0;
        end
        else
        begin
            pps_meta <= pps;       // first flop may go metastable
            pps_sync <= pps_meta;
            pps_prev <= pps_sync;
            if (pps_rise)
                pps_count <= pps_count + 1'b1;
        end
    end

endmodule

// ==== rtl/event_framer.sv ====
`timescale 1ns/100ps

module event_framer import adc_event_pkg::*;
(
    input  logic         ADA_DCO,
    input  logic         hps_fpga_reset_n,
    input  capture_t     capture,
    output record_word_t record
);

    sample_pair_t           dly [PRE_SAMPLES];  // dly[0] newest
    logic                   active;             // stream in progress
    logic [INDEX_WIDTH-1:0] cnt;                // index of the next word
    logic                   start;
    logic                   at_end;

    // triggers inside a running stream are dropped here
    assign start  = !active && capture.trigger;
    assign at_end = active && (cnt == INDEX_WIDTH'(RECORD_WORDS-1));

    ////////////////////////////////////////////////////////////
    // pre-trigger delay line
    ////////////////////////////////////////////////////////////
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            for (int i = 0; i < PRE_SAMPLES; i++)
                dly[i] <= '0;  // early trigger sees zero history
        end
        else
        begin
            dly[0] <= capture.pair;
            for (int i = 1; i < PRE_SAMPLES; i++)
                dly[i] <= dly[i-1];
        end
    end

    ////////////////////////////////////////////////////////////
    // stream control, oldest stage is always the output
    ////////////////////////////////////////////////////////////
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            active <= 1'b0;
            cnt    <= '0;
            record <= '0;
        end
        else
        begin
            if (start)
            begin
                active <= 1'b1;
                cnt    <= INDEX_WIDTH'(1);  // word 0 goes out now
            end
            else if (active)
            begin
                cnt <= cnt + 1'b1;  // wraps to 0 with the last word
                if (at_end)
                    active <= 1'b0;
            end
            record.valid     <= start || active;
            record.first     <= start;
            record.last      <= at_end;
            record.index     <= start ? '0 : cnt;
            // word 4 lands on the trigger pair itself
            record.word.pair <= dly[PRE_SAMPLES-1];
        end
    end

    // a full record always follows its first word
    first_to_last : assert property (
        @(posedge ADA_DCO) disable iff (!hps_fpga_reset_n)
        record.valid && record.first |-> ##(RECORD_WORDS-1) (record.valid && record.last)
    );

endmodule

// ==== rtl/event_buffer.sv ====
`timescale 1ns/100ps

module event_buffer import adc_event_pkg::*;
(
    input  logic                   ADA_DCO,
    input  logic                   hps_fpga_reset_n,
    input  record_word_t           record,
    input  logic [WORD_WIDTH-1:0]  sample_time,
    input  logic [INDEX_WIDTH-1:0] rd_index,   // word of the oldest slot
    input  logic                   pop,
    output sample_word_u           rd_word,
    output logic [WORD_WIDTH-1:0]  rd_time,
    output logic [COUNT_WIDTH-1:0] slot_count,
    output logic [DROP_WIDTH-1:0]  drop_count
);

    logic [WORD_WIDTH-1:0] mem   [NUM_WINDOWS*RECORD_WORDS];  // slot major
    logic [WORD_WIDTH-1:0] times [NUM_WINDOWS];

    logic [SLOT_WIDTH-1:0] wr_ptr;
    logic [SLOT_WIDTH-1:0] rd_ptr;
    logic                  discard;  // current record is being thrown away
    logic                  full;
    logic                  first_in;
    logic                  wr_en;
    logic                  commit;
    logic                  do_pop;

    function automatic logic [SLOT_WIDTH-1:0] next_slot(input logic [SLOT_WIDTH-1:0] s);
        next_slot = (s == SLOT_WIDTH'(NUM_WINDOWS-1)) ? '0 : s + 1'b1;
    endfunction

    assign full     = (slot_count == COUNT_WIDTH'(NUM_WINDOWS));
    assign first_in = record.valid && record.first;
    // drop decision is made once, on the first word
    assign wr_en    = record.valid && (record.first ? !full : !discard);
    assign commit   = record.valid && record.last && !discard;
    assign do_pop   = pop && (slot_count != '0);  // empty pop ignored

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////
    always_ff @(posedge ADA_DCO)
    begin
        if (wr_en)
            mem[{wr_ptr, record.index}] <= record.word.raw;
        if (first_in && !full)
            times[wr_ptr] <= sample_time - WORD_WIDTH'(TIME_LAG);  // back to trigger pair
    end

    // oldest slot, read straight through
    always_comb
    begin
        rd_word.raw = mem[{rd_ptr, rd_index}];
        rd_time     = times[rd_ptr];
    end

    ////////////////////////////////////////////////////////////
    // pointers, occupancy, drops
    ////////////////////////////////////////////////////////////
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            discard    <= 1'b0;
            slot_count <= '0;
            drop_count <= '0;
        end
        else
        begin
            if (first_in)
            begin
                discard <= full;
                if (full)
                    drop_count <= drop_count + 1'b1;
            end
            if (commit)
                wr_ptr <= next_slot(wr_ptr);  // slot only becomes visible here
            if (do_pop)
                rd_ptr <= next_slot(rd_ptr);
            case ({commit, do_pop})
                2'b10:   slot_count <= slot_count + 1'b1;
                2'b01:   slot_count <= slot_count - 1'b1;
                default: slot_count <= slot_count;  // both or neither
            endcase
        end
    end

    count_bound : assert property (
        @(posedge ADA_DCO) disable iff (!hps_fpga_reset_n)
        slot_count <= COUNT_WIDTH'(NUM_WINDOWS)
    );

endmodule

// ==== rtl/axil_readout.sv ====
`timescale 1ns/100ps

module axil_readout import adc_event_pkg::*;
(
    input  logic                   ADA_DCO,
    input  logic                   hps_fpga_reset_n,
    input  axil_req_t              axil_req,
    output axil_rsp_t              axil_rsp,
    input  sample_word_u           rd_word,
    input  logic [WORD_WIDTH-1:0]  rd_time,
    input  logic [COUNT_WIDTH-1:0] slot_count,
    input  logic [DROP_WIDTH-1:0]  drop_count,
    input  logic [WORD_WIDTH-1:0]  pps_count,
    output logic [INDEX_WIDTH-1:0] rd_index,
    output logic                   pop
);

    logic                  rvalid;
    logic [WORD_WIDTH-1:0] rdata;
    logic                  bvalid;
    logic                  rd_accept;
    logic                  wr_accept;
    logic                  in_data;   // address falls in the record window
    logic [WORD_WIDTH-1:0] rd_mux;
    logic [WORD_WIDTH-1:0] status;

    assign rd_accept = axil_req.arvalid && !rvalid;  // one read in flight
    assign wr_accept = axil_req.awvalid && axil_req.wvalid && !bvalid;

    // word index straight off the address bus, buffer reads through
    assign rd_index = axil_req.araddr[INDEX_WIDTH+1:2];
    assign in_data  = (axil_req.araddr[ADDR_WIDTH-1:INDEX_WIDTH+2]
                       == ADDR_DATA_BASE[ADDR_WIDTH-1:INDEX_WIDTH+2]);
    assign status   = {drop_count, {(WORD_WIDTH-DROP_WIDTH-COUNT_WIDTH){1'b0}}, slot_count};

    ////////////////////////////////////////////////////////////
    // address decode
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        if (in_data)
            rd_mux = rd_word.raw;
        else
        begin
            case (axil_req.araddr)
                ADDR_TIME:   rd_mux = rd_time;
                ADDR_STATUS: rd_mux = status;
                ADDR_PPS:    rd_mux = pps_count;
                default:     rd_mux = '0;  // pop and unmapped
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // read channel
    ////////////////////////////////////////////////////////////
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
            rvalid <= 1'b0;
        else if (rd_accept)
            rvalid <= 1'b1;
        else if (axil_req.rready)
            rvalid <= 1'b0;
    end

    // data only moves on a new address
    always_ff @(posedge ADA_DCO)
    begin
        if (rd_accept)
            rdata <= rd_mux;
    end

    ////////////////////////////////////////////////////////////
    // write channel, only the pop register reacts
    ////////////////////////////////////////////////////////////
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            bvalid <= 1'b0;
            pop    <= 1'b0;
        end
        else
        begin
            if (wr_accept)
                bvalid <= 1'b1;
            else if (axil_req.bready)
                bvalid <= 1'b0;
            pop <= wr_accept && (axil_req.awaddr == ADDR_POP);  // single cycle strobe
        end
    end

    always_comb
    begin
        axil_rsp.arready = !rvalid;
        axil_rsp.rdata   = rdata;
        axil_rsp.rresp   = 2'b00;  // always okay
        axil_rsp.rvalid  = rvalid;
        axil_rsp.awready = wr_accept;
        axil_rsp.wready  = wr_accept;  // aw and w taken together
        axil_rsp.bresp   = 2'b00;
        axil_rsp.bvalid  = bvalid;
    end

    // host stalls must not see the data move
    rdata_hold : assert property (
        @(posedge ADA_DCO) disable iff (!hps_fpga_reset_n)
        rvalid && !axil_req.rready |=> rvalid && $stable(rdata)
    );

endmodule

// ==== rtl/adc_event_top.sv ====
`timescale 1ns/100ps

module adc_event_top import adc_event_pkg::*;
(
    input  logic                 ADA_DCO,
    input  logic                 hps_fpga_reset_n,
    input  logic [ADC_WIDTH-1:0] ada_d,
    input  logic [ADC_WIDTH-1:0] adb_d,
    input  logic                 pps,
    input  axil_req_t            s_axil_req,
    output axil_rsp_t            s_axil_rsp
);

    capture_t               capture;
    record_word_t           record;
    logic [WORD_WIDTH-1:0]  sample_time;
    logic [WORD_WIDTH-1:0]  pps_count;
    sample_word_u           rd_word;
    logic [WORD_WIDTH-1:0]  rd_time;
    logic [COUNT_WIDTH-1:0] slot_count;
    logic [DROP_WIDTH-1:0]  drop_count;
    logic [INDEX_WIDTH-1:0] rd_index;
    logic                   pop;

    ////////////////////////////////////////////////////////////
    // capture -> framer -> buffer -> host
    ////////////////////////////////////////////////////////////
    sample_capture u_capture (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .ada_d            (ada_d),
        .adb_d            (adb_d),
        .capture          (capture)
    );

    event_framer u_framer (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .capture          (capture),
        .record           (record)
    );

    event_buffer u_buffer (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .record           (record),
        .sample_time      (sample_time),  // stamped on the first word
        .rd_index         (rd_index),
        .pop              (pop),
        .rd_word          (rd_word),
        .rd_time          (rd_time),
        .slot_count       (slot_count),
        .drop_count       (drop_count)
    );

    axil_readout u_readout (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .axil_req         (s_axil_req),
        .axil_rsp         (s_axil_rsp),
        .rd_word          (rd_word),
        .rd_time          (rd_time),
        .slot_count       (slot_count),
        .drop_count       (drop_count),
        .pps_count        (pps_count),
        .rd_index         (rd_index),
        .pop              (pop)
    );

    // runs beside the pipeline
    time_base u_time (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .pps              (pps),
        .sample_time      (sample_time),
        .pps_count        (pps_count)
    );

endmodule

// ==== verification/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock
(
    output logic ADA_DCO,
    output logic hps_fpga_reset_n
);

    initial
    begin
        ADA_DCO = 1'b0;
        forever #4 ADA_DCO = ~ADA_DCO;  // 8 ns period
    end

    initial
    begin
        hps_fpga_reset_n = 1'b0;
        repeat (8) @(posedge ADA_DCO);
        @(negedge ADA_DCO);  // release away from the sampling edge
        hps_fpga_reset_n = 1'b1;
    end

endmodule

// ==== verification/tb_adc_event.sv ====
`timescale 1ns/100ps

module tb_adc_event import adc_event_pkg::*;
();

    typedef struct packed {
        int gap;        // filler samples ahead of the trigger sample
        int a_val;      // channel A value of the trigger sample
        int pulses;     // pps pulses driven in the gap
        int pop_after;
    } stim_t;

    logic                 ADA_DCO;
    logic                 hps_fpga_reset_n;
    logic [ADC_WIDTH-1:0] ada_d;
    logic [ADC_WIDTH-1:0] adb_d;
    logic                 pps;
    axil_req_t            req;
    axil_rsp_t            rsp;

    stim_t                stim [14];
    logic [ADC_WIDTH-1:0] hist_a [$];   // every sample driven since reset
    logic [ADC_WIDTH-1:0] hist_b [$];
    int                   exp_q [$];    // trigger sample index per stored event
    int                   exp_drops;
    int                   last_start;   // sample index of the last accepted trigger
    logic [15:0]          lfsr;
    logic                 trig_pending;
    logic [ADC_WIDTH-1:0] trig_val;
    int                   pps_left;
    int                   pps_phase;
    int                   pps_total;
    int                   prev_trig;
    logic [WORD_WIDTH-1:0] prev_time;
    logic                 have_prev;

    tb_clock u_clock (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n)
    );

    adc_event_top dut (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .ada_d            (ada_d),
        .adb_d            (adb_d),
        .pps              (pps),
        .s_axil_req       (req),
        .s_axil_rsp       (rsp)
    );

    ////////////////////////////////////////////////////////////
    // reporting
    ////////////////////////////////////////////////////////////
    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        assert (actual === expected)
        else
            fail_stop($sformatf("Fail %s expected 0x%08h actual 0x%08h", name, expected, actual));
    endtask

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            v = (v << 1) | int'(lfsr[0]);  // one step per bit
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    ////////////////////////////////////////////////////////////
    // one sample per falling edge, with the framer and ring model
    ////////////////////////////////////////////////////////////
    task automatic tick();
        logic [ADC_WIDTH-1:0] a_raw;
        logic [ADC_WIDTH-1:0] b_raw;
        int n;
        @(negedge ADA_DCO);
        a_raw = {1'b0, (ADC_WIDTH-1)'(random_bits(ADC_WIDTH-1))};  // positive filler
        b_raw = ADC_WIDTH'(random_bits(ADC_WIDTH));
        if (trig_pending)
        begin
            a_raw = trig_val;
            trig_pending = 1'b0;
        end
        ada_d = a_raw;
        adb_d = b_raw;
        n = hist_a.size();
        hist_a.push_back(a_raw);
        hist_b.push_back(b_raw);
        // at or below the level, and no stream running
        if ($signed(a_raw) <= TRIGGER_LEVEL && n - last_start >= RECORD_WORDS)
        begin
            last_start = n;
            if (exp_q.size() == NUM_WINDOWS)
                exp_drops++;  // whole record lost
            else
                exp_q.push_back(n);
        end
        if (pps_left > 0)
        begin
            pps = (pps_phase < 3);  // three high, three low
            pps_phase++;
            if (pps_phase == 6)
            begin
                pps_phase = 0;
                pps_left--;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // AXI4-Lite host
    ////////////////////////////////////////////////////////////
    task automatic read_reg(input logic [ADDR_WIDTH-1:0] addr, input int stall,
                            output logic [WORD_WIDTH-1:0] data);
        int t;
        check("arready idle", 32'h1, 32'(rsp.arready));
        req.araddr  = addr;
        req.arvalid = 1'b1;
        req.rready  = (stall == 0);
        t = 0;
        do
        begin
            tick();
            t++;
            if (t > 20)
                fail_stop("no read response from the DUT");
        end
        while (!rsp.rvalid);
        req.arvalid = 1'b0;
        data = rsp.rdata;
        check("read response", 32'h0, 32'(rsp.rresp));  // always OKAY
        for (int i = 0; i < stall; i++)
        begin
            tick();  // host holds rready low
            assert (rsp.rvalid)
            else
                fail_stop("rvalid dropped while rready was low");
            check("read stall", data, rsp.rdata);
        end
        req.rready = 1'b1;
        tick();  // response retires here
    endtask

    task automatic write_reg(input logic [ADDR_WIDTH-1:0] addr,
                             input logic [WORD_WIDTH-1:0] data);
        int t;
        req.awaddr  = addr;
        req.awvalid = 1'b1;
        req.wdata   = data;
        req.wvalid  = 1'b1;
        req.bready  = 1'b1;
        #1;  // mid low phase, ready decode has settled
        check("awready", 32'h1, 32'(rsp.awready));
        check("wready", 32'h1, 32'(rsp.wready));
        t = 0;
        do
        begin
            tick();
            t++;
            if (t > 20)
                fail_stop("no write response from the DUT");
        end
        while (!rsp.bvalid);
        check("write response", 32'h0, 32'(rsp.bresp));
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        tick();
    endtask

    // poll until status matches the model, bounded
    task automatic wait_status(input string name);
        logic [WORD_WIDTH-1:0] expected;
        logic [WORD_WIDTH-1:0] st;
        int t;
        expected = {16'(exp_drops), 8'h00, 8'(exp_q.size())};
        t = 0;
        do
        begin
            read_reg(ADDR_STATUS, 0, st);
            t++;
        end
        while (st !== expected && t < 30);
        check({name, " status"}, expected, st);
    endtask

    task automatic check_oldest(input string name);
        logic [WORD_WIDTH-1:0] got;
        logic [WORD_WIDTH-1:0] expected;
        int t0;
        int k;
        t0 = exp_q[0];
        for (int i = 0; i < RECORD_WORDS; i++)
        begin
            k = t0 - PRE_SAMPLES + i;  // 4 before, trigger at word 4
            expected = (k < 0) ? '0 : {16'($signed(hist_a[k])), 16'($signed(hist_b[k]))};
            read_reg(ADDR_DATA_BASE + ADDR_WIDTH'(4 * i), (i % 9 == 4) ? 3 : 0, got);
            check($sformatf("%s word %0d", name, i), expected, got);
        end
        read_reg(ADDR_TIME, 5, got);
        if (have_prev)
            check({name, " time step"}, 32'(t0 - prev_trig), got - prev_time);
        prev_trig = t0;
        prev_time = got;
        have_prev = 1'b1;
    endtask

    task automatic pop_oldest(input string name);
        write_reg(ADDR_POP, 32'h1);
        exp_q.delete(0);
        wait_status({name, " pop"});
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        logic [WORD_WIDTH-1:0] got;
        string name;
        int t;
        ada_d        = '0;
        adb_d        = '0;
        pps          = 1'b0;
        req          = '0;
        lfsr         = 16'd93;
        trig_pending = 1'b0;
        trig_val     = '0;
        exp_drops    = 0;
        last_start   = -RECORD_WORDS;
        pps_left     = 0;
        pps_phase    = 0;
        pps_total    = 0;
        prev_trig    = 0;
        prev_time    = '0;
        have_prev    = 1'b0;
        // gap, channel A value, pps pulses, pop
        stim = '{
            '{30, -2170, 2, 1},  // right at the level
            '{40, -2169, 1, 0},  // one above, nothing stored
            '{45, -8192, 0, 1},
            '{33, -3000, 1, 0},
            '{50, -2171, 0, 0},
            '{36, -4096, 0, 0},
            '{41, -6000, 1, 0},
            '{34, -2500, 0, 0},
            '{60, -7000, 0, 0},
            '{38, -2200, 2, 0},
            '{44, -5000, 0, 0},
            '{35, -8000, 0, 0},
            '{47, -3333, 0, 0},
            '{39, -2999, 1, 0}   // eleventh without a pop, ring full
        };
        t = 0;
        while (!hps_fpga_reset_n)
        begin
            if (t == 50)
                fail_stop("reset was never released");
            @(negedge ADA_DCO);
            t++;
        end
        foreach (stim[e])
        begin
            name = $sformatf("event %0d", e);
            pps_left = stim[e].pulses;
            pps_total += stim[e].pulses;
            repeat (stim[e].gap) tick();
            trig_val = ADC_WIDTH'(stim[e].a_val);
            trig_pending = 1'b1;
            repeat (RECORD_WORDS + 12) tick();  // past the commit
            wait_status(name);
            read_reg(ADDR_PPS, 0, got);
            check({name, " pps"}, 32'(pps_total), got);
            if (stim[e].pop_after != 0)
            begin
                check_oldest(name);
                pop_oldest(name);
            end
        end
        read_reg(12'h090, 0, got);
        check("unmapped 0x090", '0, got);
        read_reg(12'h400, 2, got);
        check("unmapped 0x400", '0, got);
        write_reg(12'h0A0, 32'h1);  // not the pop register
        wait_status("unmapped write");
        for (int n = 0; n < NUM_WINDOWS; n++)
        begin
            if (exp_q.size() > 0)
            begin
                name = $sformatf("drain %0d", n);
                check_oldest(name);
                pop_oldest(name);
            end
        end
        write_reg(ADDR_POP, 32'h1);  // empty ring, no effect
        wait_status("empty pop");
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== verilog.f ====
rtl/adc_event_pkg.sv
rtl/sample_capture.sv
rtl/time_base.sv
rtl/event_framer.sv
rtl/event_buffer.sv
rtl/axil_readout.sv
rtl/adc_event_top.sv
verification/tb_clock.sv
verification/tb_adc_event.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, then look for the pass line in the simulation output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_adc_event -f verilog.f \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtb_adc_event 2>&1)
echo "$out"
echo "$out" | grep -qx "=== PASS ===" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
